// ==== Bender.yml ====
package:
  name: lsu_load

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_if.sv
  - rtl/load_decode.sv
  - rtl/read_buffer.sv
  - rtl/axi_read_issue.sv
  - rtl/load_result.sv
  - rtl/lsu_load_top.sv
  - target: simulation
    files:
      - bench/axi_mem_model.sv
      - bench/tb_lsu_load.sv

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import lsu_pkg::*;
(
    input  logic       g,
    input  logic       rst,
    input  logic       stall,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  addr_t      ar_addr,
    output logic       r_valid,
    input  logic       r_ready,
    output data_t      r_data,
    output logic [1:0] r_resp
);

    integer     seed = 32'ha86c;
    addr_t      pend [$];
    addr_t      head;
    logic       ar_go = 1'b0;
    logic       r_go = 1'b0;
    logic       r_valid_q = 1'b0;
    data_t      r_data_q = '0;
    logic [1:0] r_resp_q = 2'b00;

    assign ar_ready = ar_go & !stall;    // The stall input holds AR back.
    assign r_valid  = r_valid_q;
    assign r_data   = r_data_q;
    assign r_resp   = r_resp_q;

    always @(posedge g)
    begin
        if (rst)
        begin
            pend.delete();
            ar_go     <= 1'b0;
            r_go      <= 1'b0;
            r_valid_q <= 1'b0;
        end
        else
        begin
            ar_go <= ($random(seed) & 3) != 0;
            r_go  <= ($random(seed) & 1) != 0;
            if (ar_valid && ar_ready)
                pend.push_back(ar_addr);
            if (r_valid_q && r_ready)
                r_valid_q <= 1'b0;
            // Responses leave in the order their addresses arrived.
            if ((!r_valid_q || r_ready) && pend.size() != 0 && r_go)
            begin
                head = pend.pop_front();
                r_valid_q <= 1'b1;
                r_data_q  <= {head[31:2], 2'b00} ^ 32'hc3a50f96;
                r_resp_q  <= (head[15:12] == 4'hf) ? 2'b10 : 2'b00;    // SLVERR window.
            end
        end
    end

endmodule

// ==== bench/tb_lsu_load.sv ====
`timescale 1ns/1ps

module tb_lsu_load
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_SWEEP    = 24;
    localparam int N_ERR      = 4;
    localparam int N_RANDOM   = 40;
    localparam int N_STALL    = RBUF_DEPTH;
    localparam int N_REQ      = N_SWEEP + N_ERR + N_RANDOM + N_STALL;

    logic       g;
    logic       rst;
    logic       stall;
    logic       req_valid;
    logic       req_ready;
    addr_t      req_addr;
    load_size_e req_size;
    logic       req_signed;
    regid_t     req_regid;
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    logic [2:0] ar_prot;
    logic       r_valid;
    logic       r_ready;
    data_t      r_data;
    logic [1:0] r_resp;
    logic       wb_valid;
    regid_t     wb_regid;
    data_t      wb_data;
    logic       wb_fault;

    integer seed = 32'ha86c;
    logic   pending [32];
    data_t  exp_data [32];
    logic   exp_fault [32];
    addr_t  ar_expect [$];    // Word addresses of aligned loads not yet seen on AR.
    regid_t next_rid = '0;
    int     accepted = 0;
    int     wb_count = 0;

    lsu_load_top i_lsu_load_top (.*);

    axi_mem_model i_axi_mem_model (.*);

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic is_misaligned(input addr_t addr, input load_size_e size);
        return (size == size_half && addr[0]) || (size == size_word && addr[1:0] != 2'b00);
    endfunction

    function automatic data_t expect_load(input addr_t addr, input load_size_e size,
                                          input logic sgn);
        data_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        word = {addr[31:2], 2'b00} ^ 32'hc3a50f96;
        b    = word[8 * addr[1:0] +: 8];
        h    = addr[1] ? word[31:16] : word[15:0];
        case (size)
            size_byte: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
            size_half: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
            default:   return word;
        endcase
    endfunction

    task automatic send_load(input addr_t addr, input load_size_e size, input logic sgn);
        regid_t rid;
        logic   mis;
        rid      = next_rid;
        next_rid = next_rid + 1'b1;
        while (pending[rid])    // A register is reused only after its writeback.
        begin
            @(posedge g);
            #1;
        end
        mis        = is_misaligned(addr, size);
        req_valid  = 1'b1;
        req_addr   = addr;
        req_size   = size;
        req_signed = sgn;
        req_regid  = rid;
        @(posedge g);
        while (!req_ready)
            @(posedge g);
        pending[rid]   = 1'b1;
        exp_fault[rid] = mis || addr[15:12] == 4'hf;
        exp_data[rid]  = exp_fault[rid] ? '0 : expect_load(addr, size, sgn);
        accepted++;
        if (!mis)
            ar_expect.push_back({addr[31:2], 2'b00});
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (wb_count != accepted)
        begin
            @(posedge g);
            #1;
        end
    endtask

    always @(posedge g)
    begin
        if (!rst && wb_valid)
        begin
            assert (pending[wb_regid])
            else abort_run($sformatf("Writeback to register %0d with no load in flight.",
                                     wb_regid));
            assert (wb_fault === exp_fault[wb_regid])
            else abort_run($sformatf("error wb_fault: got %h expected %h (regid %h)",
                                     wb_fault, exp_fault[wb_regid], wb_regid));
            assert (wb_data === exp_data[wb_regid])
            else abort_run($sformatf("error wb_data: got %h expected %h (regid %h)",
                                     wb_data, exp_data[wb_regid], wb_regid));
            pending[wb_regid] = 1'b0;
            wb_count++;
        end
    end

    always @(posedge g)
    begin
        int hit;
        if (!rst && ar_valid)
        begin
            // Data access, unprivileged, secure.
            assert (ar_prot === 3'b000)
            else abort_run($sformatf("error ar_prot: got %h expected %h", ar_prot, 3'b000));
        end
        if (!rst && ar_valid && ar_ready)
        begin
            hit = -1;
            for (int i = 0; i < ar_expect.size(); i++)
                if (hit < 0 && ar_expect[i] == ar_addr)
                    hit = i;
            assert (hit >= 0)
            else abort_run($sformatf("AR issued for address %h with no aligned load waiting.",
                                     ar_addr));
            ar_expect.delete(hit);
        end
    end

    a_ar_hold: assert property (@(posedge g) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else abort_run("ar_valid or ar_addr changed while AR was stalled.");

    initial
    begin
        g = 1'b0;
        forever #(CLK_PERIOD / 2) g = ~g;
    end

    initial
    begin
        #((N_REQ * 40 + 200) * CLK_PERIOD);
        abort_run("Watchdog expired before all loads wrote back.");
    end

    initial
    begin
        addr_t addr;
        int    r;
        rst        = 1'b1;
        stall      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_size   = size_byte;
        req_signed = 1'b0;
        req_regid  = '0;
        for (int i = 0; i < 32; i++)
            pending[i] = 1'b0;
        repeat (5) @(posedge g);
        #1;
        rst = 1'b0;
        assert (!ar_valid && !wb_valid && !r_ready && req_ready)
        else abort_run("Outputs are not idle after reset.");

        // Every size, extension and lane, the misaligned ones included.
        for (int s = 0; s < 3; s++)
            for (int sg = 0; sg < 2; sg++)
                for (int ln = 0; ln < 4; ln++)
                begin
                    addr      = $random(seed);
                    addr[15]  = 1'b0;
                    addr[1:0] = ln[1:0];
                    send_load(addr, load_size_e'(s), sg[0]);
                end

        for (int i = 0; i < N_ERR; i++)
        begin
            addr        = $random(seed);
            addr[15:12] = 4'hf;
            addr[1:0]   = 2'b00;
            send_load(addr, load_size_e'(i % 3), i[0]);
        end

        for (int i = 0; i < N_RANDOM; i++)
        begin
            r    = $random(seed);
            addr = $random(seed);
            if (r[4:2] == 3'b000)
                addr[15:12] = 4'hf;
            else
                addr[15] = 1'b0;
            send_load(addr, load_size_e'($unsigned(r) % 3), r[5]);
        end

        wait_idle();
        stall = 1'b1;
        for (int i = 0; i < N_STALL; i++)
            send_load(32'h0000_0100 + 4 * i, size_word, 1'b0);
        assert (!req_ready)
        else abort_run("req_ready stayed high with all four entries in use.");
        repeat (10) @(posedge g);
        #1;
        assert (wb_count == accepted - N_STALL)
        else abort_run("A load wrote back while AR was stalled.");
        stall = 1'b0;
        wait_idle();

        if (wb_count == accepted && accepted == N_REQ && ar_expect.size() == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
            abort_run("Request, AR and writeback counts do not match at the end of the run.");
    end

endmodule

// ==== project.f ====
rtl/lsu_pkg.sv
rtl/lsu_if.sv
rtl/load_decode.sv
rtl/read_buffer.sv
rtl/axi_read_issue.sv
rtl/load_result.sv
rtl/lsu_load_top.sv
bench/axi_mem_model.sv
bench/tb_lsu_load.sv

// ==== rtl/axi_read_issue.sv ====
`timescale 1ns/1ps

module axi_read_issue
    import lsu_pkg::*;
(
    input  logic        g,
    input  logic        rst,
    rd_issue_if.execute iss,
    rd_resp_if.execute  rsp,
    output logic        ar_valid,
    input  logic        ar_ready,
    output addr_t       ar_addr,
    output logic [2:0]  ar_prot,
    input  logic        r_valid,
    output logic        r_ready,
    input  data_t       r_data,
    input  logic [1:0]  r_resp
);

    slot_t                         tag_q [RBUF_DEPTH];
    logic [$clog2(RBUF_DEPTH)-1:0] wr_ptr;
    logic [$clog2(RBUF_DEPTH)-1:0] rd_ptr;
    logic [$clog2(RBUF_DEPTH):0]   count;
    logic                          ar_fire;
    logic                          r_fire;
    logic                          ar_load;

    assign ar_fire = ar_valid & ar_ready;
    assign r_fire  = r_valid & r_ready;
    assign ar_load = !ar_valid && iss.valid && (count < RBUF_DEPTH);    // Needs room for the tag.

    always_ff @(posedge g)
    begin
        if (rst)
            ar_valid <= 1'b0;
        else if (ar_load)
            ar_valid <= 1'b1;
        else if (ar_fire)
            ar_valid <= 1'b0;
    end

    always_ff @(posedge g)
    begin
        if (ar_load)
            ar_addr <= {iss.addr[31:2], 2'b00};
        if (ar_fire)
            tag_q[wr_ptr] <= iss.slot;
    end

    // R beats return in AR order, so the queue head names the slot.
    always_ff @(posedge g)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (ar_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (r_fire)
                rd_ptr <= rd_ptr + 1'b1;
            case ({ar_fire, r_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign ar_prot   = AR_PROT;
    assign r_ready   = (count != '0);
    assign iss.take  = ar_fire;
    assign rsp.done  = r_fire;
    assign rsp.slot  = tag_q[rd_ptr];
    assign rsp.data  = r_data;
    assign rsp.err   = r_resp[1];    // SLVERR and DECERR both set bit 1.

    a_ar_stable: assert property (@(posedge g) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

// ==== rtl/load_decode.sv ====
`timescale 1ns/1ps

module load_decode
    import lsu_pkg::*;
(
    input  logic       g,
    input  logic       rst,
    input  logic       req_valid,
    output logic       req_ready,
    input  addr_t      req_addr,
    input  load_size_e req_size,
    input  logic       req_signed,
    input  regid_t     req_regid,
    ld_req_if.decode   ent
);

    lane_t lane;
    logic  misaligned;

    assign lane = req_addr[1:0];

    always_comb
    begin
        case (req_size)
            size_byte: misaligned = 1'b0;
            size_half: misaligned = lane[0];
            size_word: misaligned = |lane;
            default:   misaligned = 1'b1;    // Unknown size is treated as a fault.
        endcase
    end

    assign ent.valid     = req_valid;
    assign ent.addr      = req_addr;
    assign ent.size      = req_size;
    assign ent.is_signed = req_signed;
    assign ent.regid     = req_regid;
    assign ent.fault     = misaligned;
    assign req_ready     = ent.ready;

    a_size_defined: assert property (@(posedge g) disable iff (rst)
        req_valid |-> req_size inside {size_byte, size_half, size_word});

endmodule

// ==== rtl/load_result.sv ====
`timescale 1ns/1ps

module load_result
    import lsu_pkg::*;
(
    input  logic      g,
    input  logic      rst,
    rd_resp_if.result rsp,
    output logic      wb_valid,
    output regid_t    wb_regid,
    output data_t     wb_data,
    output logic      wb_fault
);

    data_t shifted;
    data_t extended;

    assign shifted = rsp.c_data >> {rsp.c_lane, 3'b000};    // Bring the lane down to bit 0.

    always_comb
    begin
        case (rsp.c_size)
            size_byte: extended = {{24{rsp.c_signed & shifted[7]}}, shifted[7:0]};
            size_half: extended = {{16{rsp.c_signed & shifted[15]}}, shifted[15:0]};
            default:   extended = shifted;
        endcase
    end

    always_ff @(posedge g)
    begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= rsp.complete;
    end

    always_ff @(posedge g)
    begin
        if (rsp.complete)
        begin
            wb_regid <= rsp.c_regid;
            wb_data  <= rsp.c_fault ? '0 : extended;
            wb_fault <= rsp.c_fault;
        end
    end

endmodule

// ==== rtl/lsu_if.sv ====
`timescale 1ns/1ps

interface ld_req_if
    import lsu_pkg::*;
();
    logic       valid;
    logic       ready;
    addr_t      addr;
    load_size_e size;
    logic       is_signed;
    regid_t     regid;
    logic       fault;

    modport decode (output valid, addr, size, is_signed, regid, fault, input ready);
    modport buffer (input valid, addr, size, is_signed, regid, fault, output ready);
endinterface

interface rd_issue_if
    import lsu_pkg::*;
();
    logic  valid;
    slot_t slot;
    addr_t addr;
    logic  take;                                // High for the cycle of the AR handshake.

    modport buffer (output valid, slot, addr, input take);
    modport execute (input valid, slot, addr, output take);
endinterface

interface rd_resp_if
    import lsu_pkg::*;
();
    logic       done;
    slot_t      slot;
    data_t      data;
    logic       err;
    logic       complete;
    lane_t      c_lane;
    load_size_e c_size;
    logic       c_signed;
    regid_t     c_regid;
    data_t      c_data;
    logic       c_fault;

    modport execute (output done, slot, data, err);
    modport buffer (input done, slot, data, err,
                    output complete, c_lane, c_size, c_signed, c_regid, c_data, c_fault);
    modport result (input complete, c_lane, c_size, c_signed, c_regid, c_data, c_fault);
endinterface

// ==== rtl/lsu_load_top.sv ====
`timescale 1ns/1ps

module lsu_load_top
    import lsu_pkg::*;
(
    input  logic       g,
    input  logic       rst,
    input  logic       req_valid,
    output logic       req_ready,
    input  addr_t      req_addr,
    input  load_size_e req_size,
    input  logic       req_signed,
    input  regid_t     req_regid,
    output logic       ar_valid,
    input  logic       ar_ready,
    output addr_t      ar_addr,
    output logic [2:0] ar_prot,
    input  logic       r_valid,
    output logic       r_ready,
    input  data_t      r_data,
    input  logic [1:0] r_resp,
    output logic       wb_valid,
    output regid_t     wb_regid,
    output data_t      wb_data,
    output logic       wb_fault
);

    ld_req_if   i_ld_req ();
    rd_issue_if i_rd_issue ();
    rd_resp_if  i_rd_resp ();

    load_decode i_load_decode (
        .g          (g),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_regid  (req_regid),
        .ent        (i_ld_req.decode)
    );

    read_buffer i_read_buffer (
        .g   (g),
        .rst (rst),
        .ent (i_ld_req.buffer),
        .iss (i_rd_issue.buffer),
        .rsp (i_rd_resp.buffer)
    );

    axi_read_issue i_axi_read_issue (
        .g        (g),
        .rst      (rst),
        .iss      (i_rd_issue.execute),
        .rsp      (i_rd_resp.execute),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_prot  (ar_prot),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_resp   (r_resp)
    );

    load_result i_load_result (
        .g        (g),
        .rst      (rst),
        .rsp      (i_rd_resp.result),
        .wb_valid (wb_valid),
        .wb_regid (wb_regid),
        .wb_data  (wb_data),
        .wb_fault (wb_fault)
    );

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    localparam int RBUF_DEPTH = 4;
    localparam logic [2:0] AR_PROT = 3'b000;    // Unprivileged, secure, data access.

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  regid_t;
    typedef logic [$clog2(RBUF_DEPTH)-1:0] slot_t;
    typedef logic [1:0]  lane_t;

    typedef enum logic [1:0]
    {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } load_size_e;

    // Life of a read buffer entry.
    typedef enum logic [1:0]
    {
        st_free,
        st_wait,
        st_issued,
        st_done
    } slot_state_e;

endpackage

// ==== rtl/read_buffer.sv ====
`timescale 1ns/1ps

module read_buffer
    import lsu_pkg::*;
(
    input  logic       g,
    input  logic       rst,
    ld_req_if.buffer   ent,
    rd_issue_if.buffer iss,
    rd_resp_if.buffer  rsp
);

    slot_state_e state_q  [RBUF_DEPTH];
    addr_t       addr_q   [RBUF_DEPTH];
    load_size_e  size_q   [RBUF_DEPTH];
    logic        signed_q [RBUF_DEPTH];
    regid_t      regid_q  [RBUF_DEPTH];
    logic        fault_q  [RBUF_DEPTH];

    logic  any_free;
    logic  any_wait;
    logic  any_done;
    slot_t free_slot;
    slot_t wait_slot;
    slot_t done_slot;
    slot_t issue_slot;
    slot_t cmp_slot;
    logic  alloc;
    logic  lock_q;
    slot_t lock_slot_q;

    // Lowest-index search over the slot states.
    always_comb
    begin
        any_free  = 1'b0;
        any_wait  = 1'b0;
        any_done  = 1'b0;
        free_slot = '0;
        wait_slot = '0;
        done_slot = '0;
        for (int i = RBUF_DEPTH - 1; i >= 0; i--)
        begin
            if (state_q[i] == st_free)
            begin
                any_free  = 1'b1;
                free_slot = slot_t'(i);
            end
            if (state_q[i] == st_wait)
            begin
                any_wait  = 1'b1;
                wait_slot = slot_t'(i);
            end
            if (state_q[i] == st_done)
            begin
                any_done  = 1'b1;
                done_slot = slot_t'(i);
            end
        end
    end

    assign ent.ready = any_free;
    assign alloc     = ent.valid & any_free;

    // Once offered, the issue slot is held until the AR handshake takes it.
    assign issue_slot = lock_q ? lock_slot_q : wait_slot;
    assign iss.valid  = any_wait;
    assign iss.slot   = issue_slot;
    assign iss.addr   = addr_q[issue_slot];

    assign cmp_slot     = rsp.done ? rsp.slot : done_slot;    // R data never waits.
    assign rsp.complete = rsp.done | any_done;
    assign rsp.c_lane   = addr_q[cmp_slot][1:0];
    assign rsp.c_size   = size_q[cmp_slot];
    assign rsp.c_signed = signed_q[cmp_slot];
    assign rsp.c_regid  = regid_q[cmp_slot];
    assign rsp.c_data   = rsp.done ? rsp.data : '0;
    assign rsp.c_fault  = rsp.done ? rsp.err : fault_q[cmp_slot];

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            for (int i = 0; i < RBUF_DEPTH; i++)
                state_q[i] <= st_free;
            lock_q <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < RBUF_DEPTH; i++)
            begin
                if (alloc && free_slot == slot_t'(i))
                    state_q[i] <= ent.fault ? st_done : st_wait;
                else if (iss.take && issue_slot == slot_t'(i))
                    state_q[i] <= st_issued;
                else if (rsp.complete && cmp_slot == slot_t'(i))
                    state_q[i] <= st_free;
            end
            if (iss.take)
                lock_q <= 1'b0;
            else if (iss.valid)
                lock_q <= 1'b1;
        end
    end

    always_ff @(posedge g)
    begin
        if (alloc)
        begin
            addr_q[free_slot]   <= ent.addr;
            size_q[free_slot]   <= ent.size;
            signed_q[free_slot] <= ent.is_signed;
            regid_q[free_slot]  <= ent.regid;
            fault_q[free_slot]  <= ent.fault;
        end
        if (iss.valid && !lock_q)
            lock_slot_q <= wait_slot;
    end

    a_take_waiting: assert property (@(posedge g) disable iff (rst)
        iss.take |-> state_q[issue_slot] == st_wait);

    a_done_issued: assert property (@(posedge g) disable iff (rst)
        rsp.done |-> state_q[rsp.slot] == st_issued);

endmodule
